// File: sim.f
uart_cfg_pkg.sv
spi_cfg_pkg.sv
uart_frame_decoder.sv
line_buffer.sv
spi_byte_master.sv
serial_bridge_top.sv
tb_serial_bridge_sva.sv
tb_serial_bridge.sv

// File: Makefile
# Verilator simulation of the serial bridge testbench
# usage: make sim, make clean, any variable can be overridden

VERILATOR ?= verilator
TOP       ?= tb_serial_bridge
LOG       ?= sim.log
FLAGS     ?= --assert
BUILD     ?= obj_dir

.PHONY: sim clean

# build, run into the log, then decide on the log contents
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f sim.f
	-$(BUILD)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_serial_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serial_bridge;

	// frames per test 9 + 4 + 18 + 3
	// bytes over spi 9 + 2 + 18 + 3
	localparam int n_frames = 34;
	localparam int n_bytes = 32;
	localparam int max_baud = 33;
	localparam int xfer_cycles = 2 * spi_cfg_pkg::half_period * spi_cfg_pkg::word_w +
		spi_cfg_pkg::gap_cycles + 14;
	// 12 frame bits plus one idle bit per frame
	localparam int timeout_cycles = n_frames * 13 * max_baud + n_bytes * xfer_cycles + 1000;

	logic CLK50MHZ, stop_bit, uart_rx, two_stop;
	logic miso = 1'b0;
	logic [uart_cfg_pkg::baud_w-1:0] baud_div;
	logic [1:0] parity_mode;
	wire sclk, mosi, cs_n, miso_strobe, parity_error, frame_error;
	wire [spi_cfg_pkg::word_w-1:0] miso_byte;

	// slave model records one entry per transfer
	logic [7:0] rx_q[$], cap_q[$], sent_q[$], exp_q[$];
	logic strobe_q[$];
	int bits_q[$];
	logic [7:0] reply [64];
	logic [7:0] slave_in, out_shift, cur_reply;
	logic [5:0] reply_idx = '0;
	logic cs_prev = 1'b1;
	logic sclk_prev = 1'b0;
	int slave_bits = 0;
	int cs_falls = 0;
	int parity_pulses = 0;
	int frame_pulses = 0;
	int mismatch_cnt = 0;
	int timeout_cnt = 0;
	int cycle_cnt = 0;
	int taken;
	logic [15:0] lfsr;

	serial_bridge_top u_dut (
		.CLK50MHZ(CLK50MHZ), .stop_bit(stop_bit), .uart_rx(uart_rx),
		.baud_div(baud_div), .parity_mode(parity_mode), .two_stop(two_stop),
		.miso(miso), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
		.miso_byte(miso_byte), .miso_strobe(miso_strobe),
		.parity_error(parity_error), .frame_error(frame_error)
	);

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	//////////////////////////////////////////////////
	// spi slave model and error pulse monitor
	//////////////////////////////////////////////////
	always @(negedge CLK50MHZ) begin
		if (!cs_prev && cs_n) begin
			// end of transfer keeps what both sides saw
			rx_q.push_back(slave_in);
			bits_q.push_back(slave_bits);
			strobe_q.push_back(miso_strobe);
			cap_q.push_back(miso_byte);
			sent_q.push_back(cur_reply);
			reply_idx = reply_idx + 1'b1;
		end else if (!cs_n) begin
			if (cs_prev) begin
				// reply MSB goes out as the transfer opens
				cs_falls = cs_falls + 1;
				cur_reply = reply[reply_idx];
				out_shift = cur_reply;
				miso = cur_reply[7];
				slave_bits = 0;
				slave_in = '0;
			end else if (!sclk_prev && sclk) begin
				slave_in = {slave_in[6:0], mosi};
				slave_bits = slave_bits + 1;
			end else if (sclk_prev && !sclk) begin
				out_shift = out_shift << 1;
				miso = out_shift[7];
			end
		end
		cs_prev = cs_n;
		sclk_prev = sclk;
	end

	always @(negedge CLK50MHZ) begin
		if (parity_error)
			parity_pulses = parity_pulses + 1;
		if (frame_error)
			frame_pulses = frame_pulses + 1;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic check_eq(input int got, input int want, input string what);
		if (got !== want) begin
			mismatch_cnt = mismatch_cnt + 1;
			$display("Fail at %0d ns: %s, got 0x%0h expected 0x%0h", $time, what, got, want);
		end
	endtask

	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		return s >> 1;
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		b = '0;
		repeat (8) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic hold_bit(input logic b);
		uart_rx = b;
		repeat (baud_div) @(negedge CLK50MHZ);
	endtask

	// one frame LSB first with optional forced errors
	task automatic uart_send(input logic [7:0] data, input bit bad_parity, input bit bad_stop);
		logic [7:0] d;
		logic par;
		d = data;
		par = ^data;
		if (parity_mode == uart_cfg_pkg::parity_odd)
			par = ~par;
		hold_bit(1'b0);
		repeat (8) begin
			hold_bit(d[0]);
			d = d >> 1;
		end
		if (parity_mode == uart_cfg_pkg::parity_even || parity_mode == uart_cfg_pkg::parity_odd)
			hold_bit(par ^ bad_parity);
		hold_bit(!bad_stop);
		if (two_stop)
			hold_bit(1'b1);
		// idle bit so the next start edge is clean
		hold_bit(1'b1);
	endtask

	task automatic send_text(input string s);
		logic [7:0] b;
		for (int i = 0; i < s.len(); i++) begin
			b = s[i];
			exp_q.push_back(b);
			uart_send(b, 1'b0, 1'b0);
		end
	endtask

	// wait for the expected line at the slave and compare each transfer
	task automatic collect_line(input string tag);
		int n;
		n = exp_q.size();
		while (rx_q.size() < taken + n)
			@(negedge CLK50MHZ);
		for (int i = 0; i < n; i++) begin
			check_eq(int'(rx_q[taken+i]), int'(exp_q[i]), $sformatf("%s byte %0d", tag, i));
			check_eq(bits_q[taken+i], spi_cfg_pkg::word_w, $sformatf("%s bit count", tag));
			check_eq(int'(strobe_q[taken+i]), 1, $sformatf("%s miso_strobe", tag));
			check_eq(int'(cap_q[taken+i]), int'(sent_q[taken+i]), $sformatf("%s miso_byte", tag));
		end
		taken = taken + n;
		exp_q.delete();
	endtask

	task automatic finish_run();
		int asrt;
		asrt = u_dut.u_spi.u_spi_sva.fail_cnt + u_dut.u_buffer.u_buf_sva.fail_cnt;
		$display("errors: %0d value mismatches, %0d assertion failures, %0d timeouts",
			mismatch_cnt, asrt, timeout_cnt);
		if (mismatch_cnt == 0 && asrt == 0 && timeout_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic idle_after_reset();
		check_eq(int'(cs_n), 1, "cs_n after reset");
		check_eq(int'(sclk), 0, "sclk after reset");
		check_eq(int'(mosi), 0, "mosi after reset");
		check_eq(int'(miso_strobe), 0, "miso_strobe after reset");
		check_eq(int'(parity_error), 0, "parity_error after reset");
		check_eq(int'(frame_error), 0, "frame_error after reset");
	endtask

	task automatic plain_line_delivery();
		int p0, f0;
		p0 = parity_pulses;
		f0 = frame_pulses;
		send_text("hi there\n");
		collect_line("plain line");
		check_eq(parity_pulses - p0, 0, "plain line parity pulses");
		check_eq(frame_pulses - f0, 0, "plain line frame pulses");
	endtask

	task automatic bad_frame_drop();
		int p0, f0;
		parity_mode = uart_cfg_pkg::parity_even;
		p0 = parity_pulses;
		f0 = frame_pulses;
		send_text("x");
		uart_send(8'h79, 1'b1, 1'b0);
		check_eq(parity_pulses - p0, 1, "parity_error pulses");
		check_eq(frame_pulses - f0, 0, "frame_error after parity fault");
		uart_send(8'h7a, 1'b0, 1'b1);
		check_eq(frame_pulses - f0, 1, "frame_error pulses");
		check_eq(parity_pulses - p0, 1, "parity_error after stop fault");
		send_text("\n");
		collect_line("bad frames");
	endtask

	task automatic full_line_release();
		logic [7:0] b;
		int c0;
		parity_mode = uart_cfg_pkg::parity_none;
		c0 = cs_falls;
		for (int i = 0; i < uart_cfg_pkg::line_depth; i++) begin
			do
				draw_byte(b);
			while (b == uart_cfg_pkg::line_end);
			exp_q.push_back(b);
			uart_send(b, 1'b0, 1'b0);
			if (i == uart_cfg_pkg::line_depth - 2)
				check_eq(cs_falls - c0, 0, "release before the 16th byte");
		end
		collect_line("full line");
		// 17th byte opens a fresh line
		do
			draw_byte(b);
		while (b == uart_cfg_pkg::line_end);
		c0 = cs_falls;
		exp_q.push_back(b);
		uart_send(b, 1'b0, 1'b0);
		check_eq(cs_falls - c0, 0, "release after the 17th byte");
		send_text("\n");
		collect_line("next line");
	endtask

	task automatic odd_parity_delivery();
		baud_div = 24'd33;
		parity_mode = uart_cfg_pkg::parity_odd;
		two_stop = 1'b1;
		send_text("ok\n");
		collect_line("odd parity line");
	endtask

	//////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////
	initial begin
		stop_bit = 1'b1;
		uart_rx = 1'b1;
		baud_div = 24'd20;
		parity_mode = uart_cfg_pkg::parity_none;
		two_stop = 1'b0;
		lfsr = 16'd42;
		taken = 0;
		for (int i = 0; i < 64; i++)
			draw_byte(reply[i[5:0]]);
		repeat (10) @(negedge CLK50MHZ);
		stop_bit = 1'b0;
		@(negedge CLK50MHZ);
		idle_after_reset();
		plain_line_delivery();
		bad_frame_drop();
		full_line_release();
		odd_parity_delivery();
		// nothing more should reach the slave in a quiet period
		repeat (200) @(negedge CLK50MHZ);
		check_eq(rx_q.size(), taken, "stray transfers after the last line");
		finish_run();
	end

	initial begin
		while (cycle_cnt < timeout_cycles) begin
			@(posedge CLK50MHZ);
			cycle_cnt = cycle_cnt + 1;
		end
		timeout_cnt = 1;
		$display("Timeout: the bridge did not deliver all lines within %0d clock cycles",
			timeout_cycles);
		finish_run();
	end

endmodule

`default_nettype wire

// File: tb_serial_bridge_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serial_bridge_sva #(
	parameter bit spi_side = 1'b1
) (
	input wire                                CLK50MHZ,
	input wire                                stop_bit,
	input wire                                sclk,
	input wire                                cs_n,
	input wire                                tx_start,
	input wire                                spi_busy,
	input wire [uart_cfg_pkg::line_cnt_w-1:0] wr_count
);

	// failure counts per property
	int fail_idle_clk = 0;
	int fail_start = 0;
	int fail_busy = 0;
	int fail_count = 0;
	int fail_cnt;

	assign fail_cnt = fail_idle_clk + fail_start + fail_busy + fail_count;

	//////////////////////////////////////////////////
	// spi pins and buffer handoff
	//////////////////////////////////////////////////
	generate
		if (spi_side) begin : g_spi
			// mode 0 clock rests low outside a transfer
			a_idle_clk: assert property (@(posedge CLK50MHZ) disable iff (stop_bit)
				cs_n |-> !sclk)
				else begin fail_idle_clk++; $error("sclk high while cs_n is high"); end

			// master takes the start one cycle later
			a_busy: assert property (@(posedge CLK50MHZ) disable iff (stop_bit)
				tx_start |=> spi_busy)
				else begin fail_busy++; $error("spi_busy missing after tx_start"); end
		end else begin : g_buf
			// buffer only starts an idle master
			a_start: assert property (@(posedge CLK50MHZ) disable iff (stop_bit)
				tx_start |-> !spi_busy)
				else begin fail_start++; $error("tx_start while spi_busy is high"); end

			// line never holds more than line_depth bytes
			a_count: assert property (@(posedge CLK50MHZ) disable iff (stop_bit)
				wr_count <= uart_cfg_pkg::line_cnt_w'(uart_cfg_pkg::line_depth))
				else begin fail_count++; $error("line buffer write count above depth"); end
		end
	endgenerate

endmodule

bind spi_byte_master tb_serial_bridge_sva #(.spi_side(1'b1)) u_spi_sva (
	.CLK50MHZ(CLK50MHZ), .stop_bit(stop_bit), .sclk(sclk), .cs_n(cs_n),
	.tx_start(tx_start), .spi_busy(spi_busy), .wr_count('0)
);

bind line_buffer tb_serial_bridge_sva #(.spi_side(1'b0)) u_buf_sva (
	.CLK50MHZ(CLK50MHZ), .stop_bit(stop_bit), .sclk(1'b0), .cs_n(1'b1),
	.tx_start(tx_start), .spi_busy(spi_busy), .wr_count(wr_count)
);

`default_nettype wire

// File: serial_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_bridge_top (
	input  wire                             CLK50MHZ,
	input  wire                             stop_bit,
	input  wire                             uart_rx,
	input  wire [uart_cfg_pkg::baud_w-1:0]  baud_div,
	input  wire [1:0]                       parity_mode,
	input  wire                             two_stop,
	input  wire                             miso,
	output wire                             sclk,
	output wire                             mosi,
	output wire                             cs_n,
	output wire [spi_cfg_pkg::word_w-1:0]   miso_byte,
	output wire                             miso_strobe,
	output wire                             parity_error,
	output wire                             frame_error
);

	// decoder to buffer
	wire [uart_cfg_pkg::data_w-1:0] rx_byte;
	wire rx_strobe;
	// buffer to spi master
	wire [uart_cfg_pkg::data_w-1:0] tx_byte;
	wire tx_start;
	wire spi_busy;

	//////////////////////////////////////////////////
	// uart in, line buffer, spi out
	//////////////////////////////////////////////////
	uart_frame_decoder u_decoder (
		.CLK50MHZ(CLK50MHZ), .stop_bit(stop_bit), .rx(uart_rx),
		.baud_div(baud_div), .parity_mode(parity_mode), .two_stop(two_stop),
		.rx_byte(rx_byte), .rx_strobe(rx_strobe),
		.parity_error(parity_error), .frame_error(frame_error)
	);

	line_buffer u_buffer (
		.CLK50MHZ(CLK50MHZ), .stop_bit(stop_bit),
		.rx_byte(rx_byte), .rx_strobe(rx_strobe), .spi_busy(spi_busy),
		.tx_byte(tx_byte), .tx_start(tx_start)
	);

	spi_byte_master u_spi (
		.CLK50MHZ(CLK50MHZ), .stop_bit(stop_bit),
		.tx_byte(tx_byte), .tx_start(tx_start), .miso(miso),
		.spi_busy(spi_busy), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
		.miso_byte(miso_byte), .miso_strobe(miso_strobe)
	);

endmodule

`default_nettype wire

// File: spi_byte_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_master (
	input  wire                             CLK50MHZ,
	input  wire                             stop_bit,
	input  wire [spi_cfg_pkg::word_w-1:0]   tx_byte,
	input  wire                             tx_start,
	input  wire                             miso,
	output logic                            spi_busy,
	output logic                            sclk,
	output logic                            mosi,
	output logic                            cs_n,
	output logic [spi_cfg_pkg::word_w-1:0]  miso_byte,
	output logic                            miso_strobe
);

	typedef enum logic [1:0] {st_idle, st_xfer, st_gap} state_t;

	state_t state;
	logic [spi_cfg_pkg::div_w-1:0] div_cnt;
	logic [spi_cfg_pkg::bit_w-1:0] bit_cnt;
	logic [spi_cfg_pkg::gap_w-1:0] gap_cnt;
	logic [spi_cfg_pkg::word_w-1:0] shift_reg;
	logic half_done;

	// end of one sclk half period
	assign half_done = (div_cnt == spi_cfg_pkg::div_w'(spi_cfg_pkg::half_period - 1));

	//////////////////////////////////////////////////
	// mode 0 transfer, MSB first
	//////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ or posedge stop_bit) begin
		if (stop_bit) begin
			state       <= st_idle;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			gap_cnt     <= '0;
			spi_busy    <= 1'b0;
			sclk        <= 1'b0;
			mosi        <= 1'b0;
			cs_n        <= 1'b1;
			miso_strobe <= 1'b0;
		end else begin
			miso_strobe <= 1'b0;
			case (state)
				st_idle: begin
					if (tx_start) begin
						// first bit is set up half a period before the rising edge
						state    <= st_xfer;
						cs_n     <= 1'b0;
						spi_busy <= 1'b1;
						mosi     <= tx_byte[spi_cfg_pkg::word_w-1];
						div_cnt  <= '0;
						bit_cnt  <= '0;
					end
				end
				st_xfer: begin
					div_cnt <= half_done ? '0 : div_cnt + 1'b1;
					if (half_done) begin
						sclk <= ~sclk;
						if (sclk) begin
							// falling edge, next bit out or word finished
							if (bit_cnt == spi_cfg_pkg::bit_w'(spi_cfg_pkg::word_w - 1)) begin
								state       <= st_gap;
								cs_n        <= 1'b1;
								mosi        <= 1'b0;
								miso_strobe <= 1'b1;
								gap_cnt     <= '0;
							end else begin
								mosi    <= shift_reg[spi_cfg_pkg::word_w-1];
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				st_gap: begin
					// busy held through the inter-word gap
					if (gap_cnt == spi_cfg_pkg::gap_w'(spi_cfg_pkg::gap_cycles - 1)) begin
						spi_busy <= 1'b0;
						state    <= st_idle;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// shift register, loads on start, takes miso on each rising edge
	always_ff @(posedge CLK50MHZ) begin
		if (state == st_idle && tx_start)
			shift_reg <= tx_byte;
		else if (state == st_xfer && half_done && !sclk)
			shift_reg <= {shift_reg[spi_cfg_pkg::word_w-2:0], miso};
	end

	// captured slave byte, valid with miso_strobe
	always_ff @(posedge CLK50MHZ) begin
		if (state == st_xfer && half_done && sclk &&
				bit_cnt == spi_cfg_pkg::bit_w'(spi_cfg_pkg::word_w - 1))
			miso_byte <= shift_reg;
	end

endmodule

`default_nettype wire

// File: line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
	input  wire                             CLK50MHZ,
	input  wire                             stop_bit,
	input  wire [uart_cfg_pkg::data_w-1:0]  rx_byte,
	input  wire                             rx_strobe,
	input  wire                             spi_busy,
	output logic [uart_cfg_pkg::data_w-1:0] tx_byte,
	output logic                            tx_start
);

	logic [uart_cfg_pkg::data_w-1:0] mem [uart_cfg_pkg::line_depth];
	logic [uart_cfg_pkg::line_cnt_w-1:0] wr_count;
	logic [uart_cfg_pkg::line_cnt_w-1:0] rd_ptr;
	logic releasing;
	logic store, send, line_done;

	// bytes are refused while a line drains
	assign store = rx_strobe && !releasing;
	// tx_start still high means busy has not risen yet
	assign send = releasing && !spi_busy && !tx_start;
	// newline or 16th byte closes the line
	assign line_done = (rx_byte == uart_cfg_pkg::line_end) ||
		(wr_count == uart_cfg_pkg::line_cnt_w'(uart_cfg_pkg::line_depth - 1));

	//////////////////////////////////////////////////
	// fill / release control
	//////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ or posedge stop_bit) begin
		if (stop_bit) begin
			wr_count  <= '0;
			rd_ptr    <= '0;
			releasing <= 1'b0;
			tx_start  <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (store) begin
				wr_count <= wr_count + 1'b1;
				if (line_done) begin
					releasing <= 1'b1;
					rd_ptr    <= '0;
				end
			end
			if (send) begin
				tx_start <= 1'b1;
				rd_ptr   <= rd_ptr + 1'b1;
				// last byte handed out, back to an empty line
				if (rd_ptr + 1'b1 == wr_count) begin
					releasing <= 1'b0;
					wr_count  <= '0;
				end
			end
		end
	end

	// byte storage, no reset needed on payload
	always_ff @(posedge CLK50MHZ) begin
		if (store)
			mem[wr_count[uart_cfg_pkg::line_ptr_w-1:0]] <= rx_byte;
	end

	// byte for the master, valid with tx_start
	always_ff @(posedge CLK50MHZ) begin
		if (send)
			tx_byte <= mem[rd_ptr[uart_cfg_pkg::line_ptr_w-1:0]];
	end

endmodule

`default_nettype wire

// File: uart_frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module uart_frame_decoder (
	input  wire                             CLK50MHZ,
	input  wire                             stop_bit,
	input  wire                             rx,
	input  wire [uart_cfg_pkg::baud_w-1:0]  baud_div,
	input  wire [1:0]                       parity_mode,
	input  wire                             two_stop,
	output logic [uart_cfg_pkg::data_w-1:0] rx_byte,
	output logic                            rx_strobe,
	output logic                            parity_error,
	output logic                            frame_error
);

	typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} state_t;

	state_t state;
	logic rx_meta, rx_sync, rx_prev;
	logic [uart_cfg_pkg::baud_w-1:0] baud_cnt;
	logic [uart_cfg_pkg::data_cnt_w-1:0] bit_cnt;
	logic [uart_cfg_pkg::data_w-1:0] shift_reg;
	logic par_acc, par_bad, stop_bad, second_stop;
	logic tick, par_en, stop_bad_now;

	// mid-bit sample point
	assign tick = (baud_cnt == '0);
	// code 3 falls back to no parity
	assign par_en = (parity_mode == uart_cfg_pkg::parity_even) ||
		(parity_mode == uart_cfg_pkg::parity_odd);
	// any low stop bit so far, current one included
	assign stop_bad_now = stop_bad | ~rx_sync;
	assign rx_byte = shift_reg;

	//////////////////////////////////////////////////
	// frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ or posedge stop_bit) begin
		if (stop_bit) begin
			state        <= st_idle;
			rx_meta      <= 1'b1;
			rx_sync      <= 1'b1;
			rx_prev      <= 1'b1;
			baud_cnt     <= '0;
			bit_cnt      <= '0;
			par_acc      <= 1'b0;
			par_bad      <= 1'b0;
			stop_bad     <= 1'b0;
			second_stop  <= 1'b0;
			rx_strobe    <= 1'b0;
			parity_error <= 1'b0;
			frame_error  <= 1'b0;
		end else begin
			// two flop synchronizer, third flop for edge detect
			rx_meta      <= rx;
			rx_sync      <= rx_meta;
			rx_prev      <= rx_sync;
			rx_strobe    <= 1'b0;
			parity_error <= 1'b0;
			frame_error  <= 1'b0;
			// baud countdown, reload one full period at each sample
			if (state != st_idle)
				baud_cnt <= tick ? baud_div - 1'b1 : baud_cnt - 1'b1;
			case (state)
				st_idle: begin
					// falling edge, aim for the middle of the start bit
					if (rx_prev && !rx_sync) begin
						baud_cnt <= baud_div >> 1;
						state    <= st_start;
					end
				end
				st_start: begin
					if (tick) begin
						// start bit gone high again means a glitch
						if (!rx_sync) begin
							state    <= st_data;
							bit_cnt  <= '0;
							par_acc  <= 1'b0;
							par_bad  <= 1'b0;
							stop_bad <= 1'b0;
						end else begin
							state <= st_idle;
						end
					end
				end
				st_data: begin
					if (tick) begin
						par_acc <= par_acc ^ rx_sync;
						if (bit_cnt == uart_cfg_pkg::data_cnt_w'(uart_cfg_pkg::data_w - 1)) begin
							state       <= par_en ? st_parity : st_stop;
							second_stop <= 1'b0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				st_parity: begin
					// even wants zero over data and parity, odd wants one
					if (tick) begin
						if (parity_mode == uart_cfg_pkg::parity_odd)
							par_bad <= ~(par_acc ^ rx_sync);
						else
							par_bad <= par_acc ^ rx_sync;
						state <= st_stop;
					end
				end
				st_stop: begin
					if (tick) begin
						if (two_stop && !second_stop) begin
							second_stop <= 1'b1;
							stop_bad    <= stop_bad_now;
						end else begin
							// bad frames are dropped, only the error pulses
							frame_error  <= stop_bad_now;
							parity_error <= par_bad;
							rx_strobe    <= !stop_bad_now && !par_bad;
							state        <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge CLK50MHZ) begin
		if (state == st_data && tick)
			shift_reg <= {rx_sync, shift_reg[uart_cfg_pkg::data_w-1:1]};
	end

endmodule

`default_nettype wire

// File: spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

	// system clocks per sclk half period
	localparam int half_period = 4;
	localparam int div_w       = $clog2(half_period);

	// bits per transfer, MSB first
	localparam int word_w = 8;
	localparam int bit_w  = $clog2(word_w);

	// idle cycles with cs_n high between two transfers
	localparam int gap_cycles = 2;
	localparam int gap_w      = $clog2(gap_cycles + 1);

endpackage

`default_nettype wire

// File: uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

	// baud divisor width, covers very slow rates at 50 MHz
	localparam int baud_w = 24;

	// parity mode input codes, code 3 behaves as none
	localparam logic [1:0] parity_none = 2'd0;
	localparam logic [1:0] parity_even = 2'd1;
	localparam logic [1:0] parity_odd  = 2'd2;

	// data bits per frame and the bit counter width
	localparam int data_w     = 8;
	localparam int data_cnt_w = $clog2(data_w);

	// line assembly
	localparam logic [data_w-1:0] line_end = 8'h0a;
	localparam int line_depth = 16;
	localparam int line_ptr_w = $clog2(line_depth);
	localparam int line_cnt_w = $clog2(line_depth + 1);

endpackage

`default_nettype wire
